// ==== filelist.f ====
+incdir+.
alu_types_pkg.sv
alu_bus_pkg.sv
cla_adder.sv
barrel_shifter.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
alu_top.sv
tb_alu_top.sv

// ==== Makefile ====
TOP = tb_alu_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

// ==== tb_alu_top.sv ====
// ALU unit testbench
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_alu_top;

   localparam int MAX_CYCLES = 6000;
   localparam int ACK_LIMIT = 8;

   logic clk;
   logic rst_n;
   alu_bus_pkg::wb_req_t wb_req;
   alu_bus_pkg::wb_rsp_t wb_rsp;

   // model of the architectural state
   logic [31:0] exp_result = '0;
   logic [4:0]  exp_flags = '0;
   int          cycles = 0;
   int          last_wait = 0;
   int          failures = 0;

   logic [31:0] corners [4] = '{32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
   // counts above 31 check the masking to five bits
   logic [31:0] shift_b [6] = '{32'd0, 32'd1, 32'd31, 32'd32, 32'd37, 32'hffff_ffe3};
   alu_types_pkg::alu_opcode_t shift_ops [3] =
      '{alu_types_pkg::op_sal, alu_types_pkg::op_shr, alu_types_pkg::op_sar};

   alu_top dut0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      failures++;
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         abort_run($sformatf("timeout: run went past %0d clock cycles", MAX_CYCLES));
      end
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
      assert (got === want) else
         abort_run($sformatf("MISMATCH at time %0t: %s got %h expected %h",
                             $time, what, got, want));
   endtask

   // read data only travels with ack
   a_dat_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      !wb_rsp.ack |-> wb_rsp.dat == '0)
      else abort_run($sformatf("MISMATCH at time %0t: read data without ack", $time));

   a_ack_answers: assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |-> $past(wb_req.stb))
      else abort_run("ack was raised with no request on the bus");

   // one classic cycle, held until ack
   task automatic bus_cycle(input logic we, input logic [2:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int waited;
      waited = 0;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      do begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > ACK_LIMIT) begin
            abort_run($sformatf("no ack within %0d cycles at address %0d", ACK_LIMIT, adr));
         end
      end while (!wb_rsp.ack);
      rdat = wb_rsp.dat;
      last_wait = waited;
      wb_req = '0;
   endtask

   task automatic write_reg(input logic [2:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic read_reg(input logic [2:0] adr, output logic [31:0] data);
      bus_cycle(1'b0, adr, 32'd0, data);
   endtask

   // x86 rules for value and flags
   task automatic predict(input alu_types_pkg::alu_opcode_t op,
                          input logic [31:0] a, input logic [31:0] b);
      logic [32:0] wide;
      logic [31:0] value;
      logic [4:0]  nib;
      logic        cf;
      logic        of;
      logic        af;
      cf = 1'b0;
      of = 1'b0;
      af = 1'b0;
      case (op)
         alu_types_pkg::op_add: begin
            wide = {1'b0, a} + {1'b0, b};
            nib = {1'b0, a[3:0]} + {1'b0, b[3:0]};
            value = wide[31:0];
            cf = wide[32];
            of = (a[31] == b[31]) && (value[31] != a[31]);
            af = nib[4];
         end
         alu_types_pkg::op_sub, alu_types_pkg::op_cmp: begin
            value = a - b;
            cf = (a < b);
            of = (a[31] != b[31]) && (value[31] != a[31]);
            af = (a[3:0] < b[3:0]);
         end
         alu_types_pkg::op_sal: begin
            wide = {1'b0, a} << b[4:0];
            value = wide[31:0];
            cf = wide[32];
         end
         alu_types_pkg::op_shr: begin
            wide = {a, 1'b0} >> b[4:0];
            value = wide[32:1];
            cf = wide[0];
         end
         default: begin
            // sar
            wide = $signed({a, 1'b0}) >>> b[4:0];
            value = wide[32:1];
            cf = wide[0];
         end
      endcase
      exp_flags = {cf, value == 32'd0, value[31], of, af};
      if (op != alu_types_pkg::op_cmp) begin
         exp_result = value;
      end
   endtask

   task automatic run_op(input alu_types_pkg::alu_opcode_t op,
                         input logic [31:0] a, input logic [31:0] b);
      logic [31:0] rd;
      write_reg(`ALU_REG_A, a);
      write_reg(`ALU_REG_B, b);
      write_reg(`ALU_REG_CMD, {29'd0, op});
      predict(op, a, b);
      read_reg(`ALU_REG_RESULT, rd);
      check_value($sformatf("%s result", op.name()), rd, exp_result);
      read_reg(`ALU_REG_FLAGS, rd);
      check_value($sformatf("%s flags", op.name()), rd, {27'd0, exp_flags});
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] rd;
      void'($urandom(32'hb83fce18));
      wb_req = '0;
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // reset values and unmapped reads
      read_reg(`ALU_REG_RESULT, rd);
      check_value("result after reset", rd, 32'd0);
      read_reg(`ALU_REG_FLAGS, rd);
      check_value("flags after reset", rd, 32'd0);
      read_reg(3'd5, rd);
      check_value("unmapped read", rd, 32'd0);

      foreach (corners[i]) begin
         foreach (corners[j]) begin
            run_op(alu_types_pkg::op_add, corners[i], corners[j]);
            run_op(alu_types_pkg::op_sub, corners[i], corners[j]);
            run_op(alu_types_pkg::op_cmp, corners[j], corners[i]);
         end
      end
      for (int i = 0; i < 35; i++) begin
         a = $urandom();
         b = $urandom();
         run_op(alu_types_pkg::op_add, a, b);
         run_op(alu_types_pkg::op_sub, a, b);
         run_op(alu_types_pkg::op_cmp, b, a);
      end

      foreach (shift_ops[k]) begin
         foreach (shift_b[j]) begin
            run_op(shift_ops[k], 32'h8000_0001, shift_b[j]);
            run_op(shift_ops[k], $urandom(), shift_b[j]);
         end
      end
      for (int i = 0; i < 35; i++) begin
         run_op(alu_types_pkg::op_sal, $urandom(), $urandom());
         run_op(alu_types_pkg::op_shr, $urandom(), $urandom());
         run_op(alu_types_pkg::op_sar, $urandom(), $urandom());
      end

      // result read straight after the command waits for done
      // an unstalled cycle right behind another takes two clocks
      write_reg(`ALU_REG_A, 32'h1234_5678);
      write_reg(`ALU_REG_B, 32'h0fed_cba9);
      write_reg(`ALU_REG_CMD, {29'd0, alu_types_pkg::op_sub});
      predict(alu_types_pkg::op_sub, 32'h1234_5678, 32'h0fed_cba9);
      read_reg(`ALU_REG_RESULT, rd);
      assert (last_wait > 2) else
         abort_run("RESULT read was acked while the operation was in flight");
      check_value("stalled result", rd, exp_result);

      // operand writes behind an issued add
      write_reg(`ALU_REG_A, 32'h0000_00ff);
      write_reg(`ALU_REG_B, 32'h0000_0f01);
      write_reg(`ALU_REG_CMD, {29'd0, alu_types_pkg::op_add});
      predict(alu_types_pkg::op_add, 32'h0000_00ff, 32'h0000_0f01);
      write_reg(`ALU_REG_A, 32'hdead_0000);
      write_reg(`ALU_REG_B, 32'h0bad_0000);
      read_reg(`ALU_REG_RESULT, rd);
      check_value("result with late operands", rd, exp_result);
      read_reg(`ALU_REG_FLAGS, rd);
      check_value("flags with late operands", rd, {27'd0, exp_flags});
      read_reg(`ALU_REG_A, rd);
      check_value("write-only read", rd, 32'd0);

      // opcodes 6 and 7 change nothing
      write_reg(`ALU_REG_CMD, 32'd6);
      write_reg(`ALU_REG_CMD, 32'd7);
      read_reg(`ALU_REG_RESULT, rd);
      check_value("result after bad opcode", rd, exp_result);
      read_reg(`ALU_REG_FLAGS, rd);
      check_value("flags after bad opcode", rd, {27'd0, exp_flags});

      if (failures == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== alu_top.sv ====
// ALU unit top level
`timescale 1ns/1ps

module alu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  alu_bus_pkg::wb_req_t wb_req,
   output alu_bus_pkg::wb_rsp_t wb_rsp
);

   logic                      issue_valid;
   alu_types_pkg::alu_issue_t issue;
   logic                      exec_valid;
   alu_types_pkg::alu_exec_t  exec;
   logic                      done;
   alu_types_pkg::alu_word_t  result_q;
   alu_types_pkg::alu_flags_t flags_q;

   alu_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .wb_req      (wb_req),
      .wb_rsp      (wb_rsp),
      .issue_valid (issue_valid),
      .issue       (issue),
      .done        (done),
      .result_q    (result_q),
      .flags_q     (flags_q)
   );

   alu_execute u_execute (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue       (issue),
      .exec_valid  (exec_valid),
      .exec        (exec)
   );

   alu_result u_result (
      .clk        (clk),
      .rst_n      (rst_n),
      .exec_valid (exec_valid),
      .exec       (exec),
      .done       (done),
      .result_q   (result_q),
      .flags_q    (flags_q)
   );

endmodule

// ==== alu_result.sv ====
// ALU result and flag registers
`timescale 1ns/1ps

module alu_result (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      exec_valid,
   input  alu_types_pkg::alu_exec_t  exec,
   output logic                      done,
   output alu_types_pkg::alu_word_t  result_q,
   output alu_types_pkg::alu_flags_t flags_q
);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         done <= 1'b0;
         result_q <= '0;
         flags_q <= '0;
      end else begin
         done <= exec_valid;
         if (exec_valid) begin
            flags_q <= exec.flags;
            // cmp leaves the previous result in place
            if (exec.wr_result) begin
               result_q <= exec.value;
            end
         end
      end
   end

   a_done_follows: assert property (@(posedge clk) disable iff (!rst_n)
      exec_valid |=> done);

   a_done_only: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> $past(exec_valid));

endmodule

// ==== alu_execute.sv ====
// ALU execute stage
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_execute (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      issue_valid,
   input  alu_types_pkg::alu_issue_t issue,
   output logic                      exec_valid,
   output alu_types_pkg::alu_exec_t  exec
);

   alu_types_pkg::alu_word_t add_b;
   alu_types_pkg::alu_word_t sum;
   alu_types_pkg::alu_word_t shifted;
   alu_types_pkg::alu_exec_t exec_d;
   logic sub_op;
   logic add_cout;
   logic add_af;
   logic add_ov;
   logic shift_cf;

   assign sub_op = (issue.opcode == alu_types_pkg::op_sub) ||
                   (issue.opcode == alu_types_pkg::op_cmp);
   // a - b as a + ~b + 1
   assign add_b  = sub_op ? ~issue.b : issue.b;

   cla_adder u_adder (
      .a    (issue.a),
      .b    (add_b),
      .cin  (sub_op),
      .sum  (sum),
      .cout (add_cout),
      .af   (add_af),
      .ov   (add_ov)
   );

   // count is the low bits of b
   barrel_shifter u_shifter (
      .value     (issue.a),
      .shamt     (issue.b[`ALU_SHAMT_WIDTH-1:0]),
      .opcode    (issue.opcode),
      .shifted   (shifted),
      .carry_out (shift_cf)
   );

   always_comb begin
      exec_d = '0;
      case (issue.opcode)
         alu_types_pkg::op_add, alu_types_pkg::op_sub, alu_types_pkg::op_cmp: begin
            exec_d.value = sum;
            // x86 borrow, the inverted carry when subtracting
            exec_d.flags.cf = add_cout ^ sub_op;
            exec_d.flags.af = add_af ^ sub_op;
            exec_d.flags.of = add_ov;
         end
         alu_types_pkg::op_sal, alu_types_pkg::op_shr, alu_types_pkg::op_sar: begin
            exec_d.value = shifted;
            exec_d.flags.cf = shift_cf;
         end
         default: exec_d.value = '0;
      endcase
      exec_d.flags.zf = (exec_d.value == '0);
      exec_d.flags.sf = exec_d.value[`ALU_WIDTH-1];
      exec_d.wr_result = (issue.opcode != alu_types_pkg::op_cmp);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exec_valid <= 1'b0;
      end else begin
         exec_valid <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      exec <= exec_d;
   end

   // decode only issues known opcodes
   a_op_defined: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid |-> issue.opcode inside {alu_types_pkg::op_add, alu_types_pkg::op_sub,
      alu_types_pkg::op_cmp, alu_types_pkg::op_sal, alu_types_pkg::op_shr,
      alu_types_pkg::op_sar});

endmodule

// ==== alu_decode.sv ====
// ALU bus slave and command decode
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_decode (
   input  logic                        clk,
   input  logic                        rst_n,
   input  alu_bus_pkg::wb_req_t        wb_req,
   output alu_bus_pkg::wb_rsp_t        wb_rsp,
   output logic                        issue_valid,
   output alu_types_pkg::alu_issue_t   issue,
   input  logic                        done,
   input  alu_types_pkg::alu_word_t    result_q,
   input  alu_types_pkg::alu_flags_t   flags_q
);

   alu_types_pkg::alu_word_t   a_q;
   alu_types_pkg::alu_word_t   b_q;
   alu_types_pkg::alu_word_t   rd_data;
   alu_types_pkg::alu_word_t   rdat_q;
   alu_types_pkg::alu_opcode_t cmd_op;
   logic cmd_ok;
   logic busy;
   logic ack_q;
   logic hit;
   logic stall;
   logic accept;
   logic launch;

   assign cmd_op = alu_types_pkg::alu_opcode_t'(wb_req.dat[$bits(cmd_op)-1:0]);

   always_comb begin
      case (cmd_op)
         alu_types_pkg::op_add, alu_types_pkg::op_sub, alu_types_pkg::op_cmp,
         alu_types_pkg::op_sal, alu_types_pkg::op_shr, alu_types_pkg::op_sar: cmd_ok = 1'b1;
         default: cmd_ok = 1'b0;
      endcase
   end

   // no new request in the ack cycle, the master still holds stb there
   assign hit    = wb_req.cyc && wb_req.stb && !ack_q;
   // hold off cmd writes and result reads until the operation is done
   assign stall  = busy && ((wb_req.we && wb_req.adr == `ALU_REG_CMD) ||
                   (!wb_req.we && (wb_req.adr == `ALU_REG_RESULT ||
                   wb_req.adr == `ALU_REG_FLAGS)));
   assign accept = hit && !stall;
   // bad opcodes are acked and dropped
   assign launch = accept && wb_req.we && wb_req.adr == `ALU_REG_CMD && cmd_ok;

   always_comb begin
      rd_data = '0;
      if (wb_req.adr == `ALU_REG_RESULT) begin
         rd_data = result_q;
      end else if (wb_req.adr == `ALU_REG_FLAGS) begin
         rd_data[$bits(flags_q)-1:0] = flags_q;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
         issue_valid <= 1'b0;
         busy <= 1'b0;
      end else begin
         ack_q <= accept;
         issue_valid <= launch;
         if (launch) begin
            busy <= 1'b1;
         end else if (done) begin
            busy <= 1'b0;
         end
      end
   end

   // operands and the captured issue copy
   always_ff @(posedge clk) begin
      if (accept && wb_req.we && wb_req.adr == `ALU_REG_A) begin
         a_q <= wb_req.dat;
      end
      if (accept && wb_req.we && wb_req.adr == `ALU_REG_B) begin
         b_q <= wb_req.dat;
      end
      if (launch) begin
         issue <= '{opcode: cmd_op, a: a_q, b: b_q};
      end
      rdat_q <= (accept && !wb_req.we) ? rd_data : '0;
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = rdat_q;

   a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack_q |=> !ack_q);

endmodule

// ==== barrel_shifter.sv ====
// Logarithmic barrel shifter
`timescale 1ns/1ps
`include "alu_macros.svh"

module barrel_shifter (
   input  alu_types_pkg::alu_word_t   value,
   input  alu_types_pkg::alu_shamt_t  shamt,
   input  alu_types_pkg::alu_opcode_t opcode,
   output alu_types_pkg::alu_word_t   shifted,
   output logic                       carry_out
);

   alu_types_pkg::alu_word_t stage;

   // five stages of 16, 8, 4, 2 and 1 bits, largest first
   // carry keeps the last bit to leave, so a later stage overrides it
   always_comb begin
      stage = value;
      carry_out = 1'b0;
      for (int i = `ALU_SHAMT_WIDTH-1; i >= 0; i--) begin
         if (shamt[i]) begin
            if (opcode == alu_types_pkg::op_sal) begin
               carry_out = stage[`ALU_WIDTH - (1 << i)];
               stage = stage << (1 << i);
            end else begin
               carry_out = stage[(1 << i) - 1];
               // sar fills with the sign bit, shr with zero
               if (opcode == alu_types_pkg::op_sar) begin
                  stage = $signed(stage) >>> (1 << i);
               end else begin
                  stage = stage >> (1 << i);
               end
            end
         end
      end
   end

   assign shifted = stage;

endmodule

// ==== cla_adder.sv ====
// Carry lookahead adder
`timescale 1ns/1ps
`include "alu_macros.svh"

module cla_adder (
   input  alu_types_pkg::alu_word_t a,
   input  alu_types_pkg::alu_word_t b,
   input  logic                     cin,
   output alu_types_pkg::alu_word_t sum,
   output logic                     cout,
   output logic                     af,
   output logic                     ov
);

   // bit generate and propagate
   alu_types_pkg::alu_word_t g;
   alu_types_pkg::alu_word_t p;

   // group terms and carries into each group
   logic [`ALU_WIDTH/`ALU_GROUP_WIDTH-1:0] grp_g;
   logic [`ALU_WIDTH/`ALU_GROUP_WIDTH-1:0] grp_p;
   logic [`ALU_WIDTH/`ALU_GROUP_WIDTH:0]   grp_c;

   // carry into every bit, plus the final carry out
   logic [`ALU_WIDTH:0] c;

   assign g = a & b;
   assign p = a ^ b;
   assign grp_c[0] = cin;

   for (genvar k = 0; k < `ALU_WIDTH/`ALU_GROUP_WIDTH; k++) begin : gen_group
      logic [`ALU_GROUP_WIDTH-1:0] gg;
      logic [`ALU_GROUP_WIDTH-1:0] pp;

      assign gg = g[k*`ALU_GROUP_WIDTH +: `ALU_GROUP_WIDTH];
      assign pp = p[k*`ALU_GROUP_WIDTH +: `ALU_GROUP_WIDTH];

      // carries inside the group, all from the group carry in
      assign c[k*4]   = grp_c[k];
      assign c[k*4+1] = gg[0] | (pp[0] & grp_c[k]);
      assign c[k*4+2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & grp_c[k]);
      assign c[k*4+3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0]) |
                        (pp[2] & pp[1] & pp[0] & grp_c[k]);

      // group generate and propagate
      assign grp_p[k] = &pp;
      assign grp_g[k] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1]) |
                        (pp[3] & pp[2] & pp[1] & gg[0]);

      // lookahead chain across groups
      assign grp_c[k+1] = grp_g[k] | (grp_p[k] & grp_c[k]);
   end

   assign c[`ALU_WIDTH] = grp_c[`ALU_WIDTH/`ALU_GROUP_WIDTH];

   assign sum  = p ^ c[`ALU_WIDTH-1:0];
   assign cout = c[`ALU_WIDTH];
   // carry out of bit 3
   assign af   = c[`ALU_GROUP_WIDTH];
   // carry into msb differs from carry out of msb
   assign ov   = c[`ALU_WIDTH-1] ^ c[`ALU_WIDTH];

endmodule

// ==== alu_bus_pkg.sv ====
// Wishbone bus types
`include "alu_macros.svh"

package alu_bus_pkg;

   // classic cycle, master side
   typedef struct packed {
      logic                       cyc;
      logic                       stb;
      logic                       we;
      logic [`ALU_ADDR_WIDTH-1:0] adr;
      logic [`ALU_WIDTH-1:0]      dat;
   } wb_req_t;

   // slave side
   typedef struct packed {
      logic                  ack;
      logic [`ALU_WIDTH-1:0] dat;
   } wb_rsp_t;

endpackage

// ==== alu_types_pkg.sv ====
// ALU datapath types
`include "alu_macros.svh"

package alu_types_pkg;

   typedef logic [`ALU_WIDTH-1:0] alu_word_t;
   typedef logic [`ALU_SHAMT_WIDTH-1:0] alu_shamt_t;

   // 6 and 7 are undefined
   typedef enum logic [2:0] {
      op_add = 3'd0,
      op_sub = 3'd1,
      op_cmp = 3'd2,
      op_sal = 3'd3,
      op_shr = 3'd4,
      op_sar = 3'd5
   } alu_opcode_t;

   typedef struct packed {
      logic cf;
      logic zf;
      logic sf;
      logic of;
      logic af;
   } alu_flags_t;

   // decode to execute
   typedef struct packed {
      alu_opcode_t opcode;
      alu_word_t   a;
      alu_word_t   b;
   } alu_issue_t;

   // execute to result, wr_result clear for cmp
   typedef struct packed {
      alu_word_t  value;
      alu_flags_t flags;
      logic       wr_result;
   } alu_exec_t;

endpackage

// ==== alu_macros.svh ====
// ALU width and register map
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// datapath widths
`define ALU_WIDTH 32
`define ALU_SHAMT_WIDTH 5
`define ALU_GROUP_WIDTH 4

// host register map
`define ALU_ADDR_WIDTH 3

// operands, write only
`define ALU_REG_A 3'd0
`define ALU_REG_B 3'd1
// a write here launches the operation
`define ALU_REG_CMD 3'd2
// read only
`define ALU_REG_RESULT 3'd3
`define ALU_REG_FLAGS 3'd4

`endif
